//--- include/usb_rx_settings.svh
`ifndef USB_RX_SETTINGS_SVH
`define USB_RX_SETTINGS_SVH

// system clocks per full-speed line bit
`define USB_RX_CLKS_PER_BIT 8

// receive buffer size in bytes
`define USB_RX_BUF_DEPTH 64

// token packets are only accepted for this function address
`define USB_RX_DEV_ADDR 7'h70

// endpoint number, split over the two token bytes on the wire
`define USB_RX_ENDPOINT 4'h4

`endif

//--- src/usb_proto_pkg.sv
package usb_proto_pkg;

    // sync pattern KJKJKJKK after NRZI decode, LSB first
    localparam logic [7:0] SYNC_BYTE = 8'h80;

    // pid low nibble, the high nibble is its complement
    localparam logic [3:0] PID_OUT   = 4'h1;
    localparam logic [3:0] PID_IN    = 4'h9;
    localparam logic [3:0] PID_DATA0 = 4'h3;
    localparam logic [3:0] PID_DATA1 = 4'hB;
    localparam logic [3:0] PID_ACK   = 4'h2;
    localparam logic [3:0] PID_NAK   = 4'hA;

    // packet kind reported to the host side
    typedef enum logic [2:0] {
        PKT_IDLE  = 3'd0,
        PKT_IN    = 3'd1,
        PKT_OUT   = 3'd2,
        PKT_DATA  = 3'd3,
        PKT_ACK   = 3'd4,
        PKT_NAK   = 3'd5,
        PKT_ERROR = 3'd6
    } rx_packet_t;

endpackage

//--- src/usb_rx_pkg.sv
package usb_rx_pkg;

    // receive control unit states
    typedef enum logic [3:0] {
        idle,
        load_sync,
        load_pid,
        data_state,
        token,
        token_number,
        error_state,
        wait_eop,
        transfer_done
    } rcu_state_t;

endpackage

//--- src/usb_byte_if.sv
`timescale 1ns/1ns

interface usb_byte_if;

    logic [7:0] rcv_data;
    logic       one_byte;
    logic       eop;
    logic       edge_start;
    logic       timer_clear;

    modport decoder (
        output rcv_data, one_byte, eop, edge_start,
        input  timer_clear
    );

    modport control (
        input  rcv_data, one_byte, eop, edge_start,
        output timer_clear
    );

endinterface

//--- src/usb_rx_decoder.sv
`timescale 1ns/1ns
`include "usb_rx_settings.svh"

module usb_rx_decoder (
    input logic clk,
    input logic n_rst,
    input logic d_plus,
    input logic d_minus,
    usb_byte_if.decoder bus
);

    localparam int CLKS = `USB_RX_CLKS_PER_BIT;
    localparam int HALF = CLKS / 2;
    localparam int TW = $clog2(CLKS);
    localparam int SW = $clog2(CLKS + 1);

    logic [1:0] dp_sync;
    logic [1:0] dm_sync;
    logic [1:0] line_prev;
    logic       active;
    logic [TW-1:0] timer;
    logic [SW-1:0] se0_cnt;
    logic       last_level;
    logic [2:0] ones_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic [7:0] rcv_data;
    logic       one_byte;
    logic       eop;

    logic dp;
    logic dm;
    logic line_j;
    logic line_k;
    logic line_se0;
    logic transition;
    logic start;
    logic clear;
    logic sample;
    logic nrzi_bit;
    logic stuffed;

    assign dp = dp_sync[1];
    assign dm = dm_sync[1];
    assign line_j = dp && !dm;
    assign line_k = !dp && dm;
    assign line_se0 = !dp && !dm;
    assign transition = ({dp, dm} != line_prev);

    // idle J going to K opens a packet
    assign start = !active && line_k && (line_prev == 2'b10);
    assign clear = (bus.timer_clear && !start) || (eop && line_j);
    assign sample = active && !clear && !line_se0 && (timer == TW'(HALF));

    // no level change means a one
    assign nrzi_bit = (dp == last_level);
    assign stuffed = (ones_cnt == 3'd6);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_sync    <= 2'b11;
            dm_sync    <= 2'b00;
            line_prev  <= 2'b10;
            active     <= 1'b0;
            timer      <= '0;
            se0_cnt    <= '0;
            last_level <= 1'b1;
            ones_cnt   <= '0;
            bit_cnt    <= '0;
            one_byte   <= 1'b0;
            eop        <= 1'b0;
        end else begin
            dp_sync   <= {dp_sync[0], d_plus};
            dm_sync   <= {dm_sync[0], d_minus};
            line_prev <= {dp, dm};
            one_byte  <= 1'b0;
            if (start || clear) begin
                active     <= start;
                timer      <= start ? TW'(1) : '0;
                se0_cnt    <= '0;
                last_level <= 1'b1;
                ones_cnt   <= '0;
                bit_cnt    <= '0;
                eop        <= 1'b0;
            end else if (active) begin
                // realign the bit timer on every line change
                if (transition) begin
                    timer <= TW'(1);
                end else if (timer == TW'(CLKS - 1)) begin
                    timer <= '0;
                end else begin
                    timer <= timer + 1'b1;
                end

                if (line_se0) begin
                    if (se0_cnt == SW'(CLKS - 1)) begin
                        eop <= 1'b1;
                    end else begin
                        se0_cnt <= se0_cnt + 1'b1;
                    end
                end else begin
                    se0_cnt <= '0;
                end

                if (sample) begin
                    last_level <= dp;
                    if (stuffed) begin
                        ones_cnt <= '0;
                    end else begin
                        ones_cnt <= nrzi_bit ? ones_cnt + 1'b1 : 3'd0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            one_byte <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (sample && !stuffed) begin
            shift <= {nrzi_bit, shift[7:1]};
            if (bit_cnt == 3'd7) begin
                rcv_data <= {nrzi_bit, shift[7:1]};
            end
        end
    end

    assign bus.rcv_data = rcv_data;
    assign bus.one_byte = one_byte;
    assign bus.eop = eop;
    assign bus.edge_start = start;

endmodule

//--- src/rcu.sv
`timescale 1ns/1ns
`include "usb_rx_settings.svh"

module rcu (
    input  logic clk,
    input  logic n_rst,
    usb_byte_if.control bus,
    input  logic buffer_full,
    output logic w_enable,
    output logic [7:0] w_data,
    output usb_proto_pkg::rx_packet_t rx_packet,
    output logic packet_valid,
    output logic receiving,
    output logic r_error
);

    usb_rx_pkg::rcu_state_t state;
    usb_rx_pkg::rcu_state_t next_state;
    usb_rx_pkg::rcu_state_t last_state;
    usb_proto_pkg::rx_packet_t next_rx_packet;

    logic ep_low;
    logic next_ep_low;
    logic token_miss;
    logic next_token_miss;
    logic byte_done;
    logic next_byte_done;
    logic one_byte_d;
    logic one_byte_pulse;
    logic timer_clear;
    logic report;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state        <= usb_rx_pkg::idle;
            last_state   <= usb_rx_pkg::idle;
            rx_packet    <= usb_proto_pkg::PKT_IDLE;
            ep_low       <= 1'b0;
            token_miss   <= 1'b0;
            byte_done    <= 1'b0;
            one_byte_d   <= 1'b0;
            packet_valid <= 1'b0;
        end else begin
            state        <= next_state;
            last_state   <= state;
            rx_packet    <= next_rx_packet;
            ep_low       <= next_ep_low;
            token_miss   <= next_token_miss;
            byte_done    <= next_byte_done;
            one_byte_d   <= bus.one_byte;
            packet_valid <= report;
        end
    end

    assign one_byte_pulse = bus.one_byte && !one_byte_d;

    // first cycle in a final state, ignored tokens stay silent
    assign report = (state != last_state) &&
                    ((state == usb_rx_pkg::error_state) ||
                     ((state == usb_rx_pkg::transfer_done) && !token_miss));

    always_comb begin
        next_state      = state;
        next_rx_packet  = rx_packet;
        next_ep_low     = ep_low;
        next_token_miss = token_miss;
        next_byte_done  = byte_done;
        case (state)
            usb_rx_pkg::idle,
            usb_rx_pkg::error_state,
            usb_rx_pkg::transfer_done: begin
                if (bus.edge_start) begin
                    next_state      = usb_rx_pkg::load_sync;
                    next_token_miss = 1'b0;
                end
            end
            usb_rx_pkg::load_sync: begin
                if (one_byte_pulse) begin
                    if (bus.rcv_data == usb_proto_pkg::SYNC_BYTE) begin
                        next_state = usb_rx_pkg::load_pid;
                    end else begin
                        next_state = usb_rx_pkg::error_state;
                    end
                end else if (bus.eop) begin
                    next_state = usb_rx_pkg::error_state;
                end
            end
            usb_rx_pkg::load_pid: begin
                if (one_byte_pulse) begin
                    case (bus.rcv_data[3:0])
                        usb_proto_pkg::PID_OUT: begin
                            next_state     = usb_rx_pkg::token;
                            next_rx_packet = usb_proto_pkg::PKT_OUT;
                        end
                        usb_proto_pkg::PID_IN: begin
                            next_state     = usb_rx_pkg::token;
                            next_rx_packet = usb_proto_pkg::PKT_IN;
                        end
                        usb_proto_pkg::PID_DATA0,
                        usb_proto_pkg::PID_DATA1: begin
                            next_state     = usb_rx_pkg::data_state;
                            next_rx_packet = usb_proto_pkg::PKT_DATA;
                            next_byte_done = 1'b0;
                        end
                        usb_proto_pkg::PID_ACK: begin
                            next_state     = usb_rx_pkg::wait_eop;
                            next_rx_packet = usb_proto_pkg::PKT_ACK;
                        end
                        usb_proto_pkg::PID_NAK: begin
                            next_state     = usb_rx_pkg::wait_eop;
                            next_rx_packet = usb_proto_pkg::PKT_NAK;
                        end
                        default: begin
                            next_state     = usb_rx_pkg::error_state;
                            next_rx_packet = usb_proto_pkg::PKT_ERROR;
                        end
                    endcase
                end else if (bus.eop) begin
                    next_state     = usb_rx_pkg::error_state;
                    next_rx_packet = usb_proto_pkg::PKT_ERROR;
                end
            end
            usb_rx_pkg::token: begin
                if (one_byte_pulse) begin
                    // address in bits 6:0, endpoint lsb in bit 7
                    if (bus.rcv_data[6:0] != `USB_RX_DEV_ADDR) begin
                        next_token_miss = 1'b1;
                    end
                    next_ep_low = bus.rcv_data[7];
                    next_state  = usb_rx_pkg::token_number;
                end else if (bus.eop) begin
                    next_state     = usb_rx_pkg::error_state;
                    next_rx_packet = usb_proto_pkg::PKT_ERROR;
                end
            end
            usb_rx_pkg::token_number: begin
                if (one_byte_pulse) begin
                    if ({bus.rcv_data[2:0], ep_low} != `USB_RX_ENDPOINT) begin
                        next_token_miss = 1'b1;
                    end
                    next_state = usb_rx_pkg::wait_eop;
                end else if (bus.eop) begin
                    next_state     = usb_rx_pkg::error_state;
                    next_rx_packet = usb_proto_pkg::PKT_ERROR;
                end
            end
            usb_rx_pkg::data_state: begin
                if (one_byte_pulse) begin
                    // the line cannot wait for a full buffer
                    if (buffer_full) begin
                        next_state     = usb_rx_pkg::error_state;
                        next_rx_packet = usb_proto_pkg::PKT_ERROR;
                    end else begin
                        next_byte_done = 1'b1;
                    end
                end else if (bus.eop) begin
                    if (byte_done) begin
                        next_state = usb_rx_pkg::transfer_done;
                    end else begin
                        next_state     = usb_rx_pkg::error_state;
                        next_rx_packet = usb_proto_pkg::PKT_ERROR;
                    end
                end
            end
            usb_rx_pkg::wait_eop: begin
                if (bus.eop) begin
                    next_state = usb_rx_pkg::transfer_done;
                    if (token_miss) begin
                        next_rx_packet = usb_proto_pkg::PKT_IDLE;
                    end
                end
            end
            default: begin
                next_state = usb_rx_pkg::idle;
            end
        endcase
    end

    always_comb begin
        receiving   = 1'b0;
        r_error     = 1'b0;
        w_enable    = 1'b0;
        timer_clear = 1'b0;
        case (state)
            usb_rx_pkg::load_sync,
            usb_rx_pkg::load_pid,
            usb_rx_pkg::token,
            usb_rx_pkg::token_number,
            usb_rx_pkg::wait_eop: begin
                receiving = 1'b1;
            end
            usb_rx_pkg::data_state: begin
                receiving = 1'b1;
                w_enable  = one_byte_pulse && !buffer_full;
            end
            usb_rx_pkg::error_state: begin
                r_error = 1'b1;
            end
            usb_rx_pkg::transfer_done: begin
                timer_clear = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign w_data = bus.rcv_data;
    assign bus.timer_clear = timer_clear;

endmodule

//--- src/usb_rx_buffer.sv
`timescale 1ns/1ns
`include "usb_rx_settings.svh"

module usb_rx_buffer (
    input  logic clk,
    input  logic n_rst,
    input  logic w_enable,
    input  logic [7:0] w_data,
    input  logic r_enable,
    output logic [7:0] r_data,
    output logic full,
    output logic empty,
    output logic [$clog2(`USB_RX_BUF_DEPTH + 1) - 1:0] occupancy
);

    localparam int DEPTH = `USB_RX_BUF_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_write;
    logic do_read;

    assign do_write = w_enable && !full;
    assign do_read = r_enable && !empty;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= w_data;
        end
    end

    // oldest byte is visible without a read
    assign r_data = mem[rd_ptr];
    assign full = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign occupancy = count;

endmodule

//--- src/usb_rx.sv
`timescale 1ns/1ns
`include "usb_rx_settings.svh"

module usb_rx (
    input  logic clk,
    input  logic n_rst,
    input  logic d_plus,
    input  logic d_minus,
    input  logic r_enable,
    output logic [7:0] rx_data,
    output logic [$clog2(`USB_RX_BUF_DEPTH + 1) - 1:0] buffer_occupancy,
    output logic buffer_empty,
    output usb_proto_pkg::rx_packet_t rx_packet,
    output logic packet_valid,
    output logic receiving,
    output logic r_error
);

    logic       w_enable;
    logic [7:0] w_data;
    logic       buffer_full;

    usb_byte_if u_byte_if ();

    usb_rx_decoder u_decoder (
        .clk     (clk),
        .n_rst   (n_rst),
        .d_plus  (d_plus),
        .d_minus (d_minus),
        .bus     (u_byte_if.decoder)
    );

    rcu u_rcu (
        .clk          (clk),
        .n_rst        (n_rst),
        .bus          (u_byte_if.control),
        .buffer_full  (buffer_full),
        .w_enable     (w_enable),
        .w_data       (w_data),
        .rx_packet    (rx_packet),
        .packet_valid (packet_valid),
        .receiving    (receiving),
        .r_error      (r_error)
    );

    usb_rx_buffer u_buffer (
        .clk       (clk),
        .n_rst     (n_rst),
        .w_enable  (w_enable),
        .w_data    (w_data),
        .r_enable  (r_enable),
        .r_data    (rx_data),
        .full      (buffer_full),
        .empty     (buffer_empty),
        .occupancy (buffer_occupancy)
    );

endmodule

//--- sim/usb_rx_asserts.sv
`timescale 1ns/1ns

module usb_rx_asserts (
    input logic clk,
    input logic n_rst,
    input usb_rx_pkg::rcu_state_t state,
    input logic w_enable,
    input logic packet_valid,
    input logic r_error
);

    int wen_fails = 0;
    int valid_fails = 0;
    int error_fails = 0;

    // payload writes only while a data packet is open
    wen_in_data: assert property (@(posedge clk) disable iff (!n_rst)
        w_enable |-> state == usb_rx_pkg::data_state)
        else begin
            wen_fails++;
            $error("w_enable high outside data_state");
        end

    valid_single: assert property (@(posedge clk) disable iff (!n_rst)
        packet_valid |=> !packet_valid)
        else begin
            valid_fails++;
            $error("packet_valid longer than one clock");
        end

    error_level: assert property (@(posedge clk) disable iff (!n_rst)
        r_error == (state == usb_rx_pkg::error_state))
        else begin
            error_fails++;
            $error("r_error does not match error_state");
        end

endmodule

bind rcu usb_rx_asserts u_asserts (
    .clk          (clk),
    .n_rst        (n_rst),
    .state        (state),
    .w_enable     (w_enable),
    .packet_valid (packet_valid),
    .r_error      (r_error)
);

//--- sim/usb_rx_tb.sv
`timescale 1ns/1ns
`include "usb_rx_settings.svh"

module usb_rx_tb;

    localparam int CLKS = `USB_RX_CLKS_PER_BIT;
    localparam int DEPTH = `USB_RX_BUF_DEPTH;
    localparam int OW = $clog2(DEPTH + 1);
    localparam int TIMEOUT = 2000;
    localparam logic [6:0] DEV_ADDR = `USB_RX_DEV_ADDR;
    localparam logic [3:0] ENDP = `USB_RX_ENDPOINT;

    logic clk;
    logic n_rst;
    logic d_plus;
    logic d_minus;
    logic r_enable;
    logic [7:0] rx_data;
    logic [OW-1:0] buffer_occupancy;
    logic buffer_empty;
    usb_proto_pkg::rx_packet_t rx_packet;
    logic packet_valid;
    logic receiving;
    logic r_error;

    int errors = 0;
    int checks = 0;
    int valid_count = 0;
    int assert_fails;
    int unsigned seed_dummy;
    usb_proto_pkg::rx_packet_t seen_packet;
    logic seen_error;
    logic line_level;
    int ones_run;
    logic [7:0] tx_bytes[$];

    usb_rx u_usb_rx (
        .clk              (clk),
        .n_rst            (n_rst),
        .d_plus           (d_plus),
        .d_minus          (d_minus),
        .r_enable         (r_enable),
        .rx_data          (rx_data),
        .buffer_occupancy (buffer_occupancy),
        .buffer_empty     (buffer_empty),
        .rx_packet        (rx_packet),
        .packet_valid     (packet_valid),
        .receiving        (receiving),
        .r_error          (r_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // latch what the DUT reports with each packet_valid pulse
    always @(posedge clk) begin
        if (packet_valid) begin
            valid_count <= valid_count + 1;
            seen_packet <= rx_packet;
            seen_error  <= r_error;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic hold_line(input logic dp, input logic dm, input int bits);
        d_plus = dp;
        d_minus = dm;
        repeat (bits * CLKS) begin
            @(posedge clk);
            #1;
        end
    endtask

    // nrzi: a zero toggles the line
    task automatic send_bit(input logic b);
        if (!b) begin
            line_level = !line_level;
        end
        hold_line(line_level, !line_level, 1);
        if (b) begin
            ones_run++;
            if (ones_run == 6) begin
                line_level = !line_level;
                hold_line(line_level, !line_level, 1);
                ones_run = 0;
            end
        end else begin
            ones_run = 0;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        int i;
        for (i = 0; i < 8; i++) begin
            send_bit(value[i]);
        end
    endtask

    task automatic send_packet(input logic [7:0] sync, input logic [3:0] pid);
        int i;
        line_level = 1'b1;
        ones_run = 0;
        send_byte(sync);
        send_byte({~pid, pid});
        for (i = 0; i < tx_bytes.size(); i++) begin
            send_byte(tx_bytes[i]);
        end
        // eop then idle J
        hold_line(1'b0, 1'b0, 2);
        hold_line(1'b1, 1'b0, 4);
    endtask

    task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
                              input logic [3:0] ep);
        tx_bytes.delete();
        tx_bytes.push_back({ep[0], addr});
        tx_bytes.push_back({5'h00, ep[3:1]});
        send_packet(usb_proto_pkg::SYNC_BYTE, pid);
    endtask

    task automatic wait_packet(input string name, input int base, input logic expect_valid);
        int cycles;
        cycles = 0;
        while (valid_count == base && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (expect_valid && valid_count == base) begin
            errors++;
            $display("%s: no packet_valid within %0d clocks", name, TIMEOUT);
        end else if (!expect_valid && valid_count != base) begin
            errors++;
            $display("%s: packet_valid seen for a packet that should be ignored", name);
        end
    endtask

    task automatic read_back(input string name, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            check(name, 32'(tx_bytes[i]), 32'(rx_data));
            r_enable = 1'b1;
            @(posedge clk);
            #1;
            r_enable = 1'b0;
        end
        check({name, " empty"}, 32'd1, 32'(buffer_empty));
    endtask

    function automatic logic [7:0] random_byte();
        if ($urandom % 3 == 0) begin
            return 8'hFF;
        end
        return 8'($urandom);
    endfunction

    task automatic run_handshake_test();
        int base;
        tx_bytes.delete();
        base = valid_count;
        send_packet(usb_proto_pkg::SYNC_BYTE, usb_proto_pkg::PID_ACK);
        wait_packet("ack", base, 1'b1);
        check("ack kind", 32'(usb_proto_pkg::PKT_ACK), 32'(seen_packet));
        check("ack empty", 32'd1, 32'(buffer_empty));
        base = valid_count;
        send_packet(usb_proto_pkg::SYNC_BYTE, usb_proto_pkg::PID_NAK);
        wait_packet("nak", base, 1'b1);
        check("nak kind", 32'(usb_proto_pkg::PKT_NAK), 32'(seen_packet));
        check("nak empty", 32'd1, 32'(buffer_empty));
    endtask

    task automatic run_data_test();
        int p;
        int i;
        int n;
        int base;
        logic [3:0] pid;
        for (p = 0; p < 6; p++) begin
            n = 1 + int'($urandom % 20);
            tx_bytes.delete();
            // first packet is all ones, heavy stuffing
            for (i = 0; i < n; i++) begin
                tx_bytes.push_back((p == 0) ? 8'hFF : random_byte());
            end
            pid = (p % 2 == 0) ? usb_proto_pkg::PID_DATA0 : usb_proto_pkg::PID_DATA1;
            base = valid_count;
            send_packet(usb_proto_pkg::SYNC_BYTE, pid);
            wait_packet("data", base, 1'b1);
            check("data kind", 32'(usb_proto_pkg::PKT_DATA), 32'(seen_packet));
            check("data r_error", 32'd0, 32'(seen_error));
            check("data occupancy", 32'(n), 32'(buffer_occupancy));
            read_back("data readback", n);
        end
    endtask

    task automatic run_token_test();
        int base;
        base = valid_count;
        send_token(usb_proto_pkg::PID_IN, DEV_ADDR, ENDP);
        wait_packet("token in", base, 1'b1);
        check("token in kind", 32'(usb_proto_pkg::PKT_IN), 32'(seen_packet));
        base = valid_count;
        send_token(usb_proto_pkg::PID_OUT, DEV_ADDR, ENDP);
        wait_packet("token out", base, 1'b1);
        check("token out kind", 32'(usb_proto_pkg::PKT_OUT), 32'(seen_packet));
        base = valid_count;
        send_token(usb_proto_pkg::PID_IN, DEV_ADDR ^ 7'h01, ENDP);
        wait_packet("token other address", base, 1'b0);
        check("token other address kind", 32'(usb_proto_pkg::PKT_IDLE), 32'(rx_packet));
        base = valid_count;
        send_token(usb_proto_pkg::PID_OUT, DEV_ADDR, ENDP ^ 4'h8);
        wait_packet("token other endpoint", base, 1'b0);
        check("token other endpoint kind", 32'(usb_proto_pkg::PKT_IDLE), 32'(rx_packet));
        check("token empty", 32'd1, 32'(buffer_empty));
    endtask

    task automatic run_error_test();
        int base;
        tx_bytes.delete();
        base = valid_count;
        send_packet(usb_proto_pkg::SYNC_BYTE ^ 8'hC0, usb_proto_pkg::PID_ACK);
        wait_packet("bad sync", base, 1'b1);
        check("bad sync r_error", 32'd1, 32'(seen_error));
        base = valid_count;
        send_packet(usb_proto_pkg::SYNC_BYTE, 4'h5);
        wait_packet("unknown pid", base, 1'b1);
        check("unknown pid kind", 32'(usb_proto_pkg::PKT_ERROR), 32'(seen_packet));
        check("unknown pid r_error", 32'd1, 32'(seen_error));
        check("unknown pid r_error level", 32'd1, 32'(r_error));
    endtask

    task automatic run_overflow_test();
        int i;
        int base;
        tx_bytes.delete();
        for (i = 0; i < DEPTH + 6; i++) begin
            tx_bytes.push_back(random_byte());
        end
        base = valid_count;
        send_packet(usb_proto_pkg::SYNC_BYTE, usb_proto_pkg::PID_DATA1);
        wait_packet("overflow", base, 1'b1);
        check("overflow kind", 32'(usb_proto_pkg::PKT_ERROR), 32'(seen_packet));
        check("overflow r_error", 32'd1, 32'(seen_error));
        check("overflow occupancy", 32'(DEPTH), 32'(buffer_occupancy));
        read_back("overflow readback", DEPTH);
    endtask

    task automatic run_receiving_test();
        int i;
        int base;
        tx_bytes.delete();
        for (i = 0; i < 4; i++) begin
            tx_bytes.push_back(random_byte());
        end
        check("receiving idle", 32'd0, 32'(receiving));
        base = valid_count;
        fork
            send_packet(usb_proto_pkg::SYNC_BYTE, usb_proto_pkg::PID_DATA0);
            begin
                // 20 bits in lands inside the payload
                repeat (20 * CLKS) begin
                    @(posedge clk);
                    #1;
                end
                check("receiving mid payload", 32'd1, 32'(receiving));
            end
        join
        wait_packet("receiving", base, 1'b1);
        check("receiving after", 32'd0, 32'(receiving));
        read_back("receiving readback", 4);
    endtask

    initial begin
        seed_dummy = $urandom(20469);
        n_rst = 1'b0;
        d_plus = 1'b1;
        d_minus = 1'b0;
        r_enable = 1'b0;
        line_level = 1'b1;
        ones_run = 0;
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(posedge clk);
        #1;
        check("reset receiving", 32'd0, 32'(receiving));
        check("reset r_error", 32'd0, 32'(r_error));
        check("reset packet_valid", 32'd0, 32'(packet_valid));
        check("reset kind", 32'(usb_proto_pkg::PKT_IDLE), 32'(rx_packet));
        check("reset empty", 32'd1, 32'(buffer_empty));
        check("reset occupancy", 32'd0, 32'(buffer_occupancy));
        hold_line(1'b1, 1'b0, 4);
        check("idle receiving", 32'd0, 32'(receiving));

        run_handshake_test();
        run_data_test();
        run_token_test();
        run_error_test();
        run_overflow_test();
        run_receiving_test();

        assert_fails = u_usb_rx.u_rcu.u_asserts.wen_fails +
                       u_usb_rx.u_rcu.u_asserts.valid_fails +
                       u_usb_rx.u_rcu.u_asserts.error_fails;
        if (assert_fails != 0) begin
            errors += assert_fails;
            $display("control unit assertions failed %0d times", assert_fails);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
src/usb_proto_pkg.sv
src/usb_rx_pkg.sv
src/usb_byte_if.sv
src/usb_rx_decoder.sv
src/rcu.sv
src/usb_rx_buffer.sv
src/usb_rx.sv
sim/usb_rx_asserts.sv
sim/usb_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= usb_rx_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG ?= test failed

SOURCES := $(wildcard src/*.sv sim/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails on a nonzero exit or when the log holds the fail message
run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
